/* Bender.yml */
package:
  name: asg

sources:
  - files:
      - hw/asg_pkg.sv
      - hw/asg_regs.sv
      - hw/asg_table.sv
      - hw/asg_chan.sv
      - hw/asg_scale.sv
      - hw/asg_top.sv
  - target: test
    files:
      - testbench/asg_chk.sv
      - testbench/asg_tb.sv

/* flist.f */
hw/asg_pkg.sv
hw/asg_regs.sv
hw/asg_table.sv
hw/asg_chan.sv
hw/asg_scale.sv
hw/asg_top.sv
testbench/asg_chk.sv
testbench/asg_tb.sv

/* hw/asg_chan.sv */
/*
 * Channel pointer sequencer
 *   external trigger sampling and rising edge detect
 *   IDLE/RUN state machine with software or external start
 *   14.16 style fixed point pointer with wrap or single pass
 *   table read index, delayed run level and pointer readback
 */

`timescale 1ns/1ps

module asg_chan #(
  parameter int TABLE_AW = 14
) (
  input  logic                 dac_clk,
  input  logic                 i_rst,
  input  logic                 i_trig,
  input  asg_pkg::trig_src_e   i_trig_src,
  input  logic                 i_sw_start,
  input  logic                 i_wrap,
  input  logic                 i_hold,
  input  logic [TABLE_AW-1:0]  i_size,
  input  logic [TABLE_AW-1:0]  i_start,
  input  logic [TABLE_AW+15:0] i_step,
  output logic [TABLE_AW-1:0]  o_raddr,
  output logic                 o_run_d,
  output logic [TABLE_AW-1:0]  o_ptr
);
  import asg_pkg::*;

  localparam int PW = TABLE_AW + 16;  // integer plus 16 fraction bits

  chan_state_e   state;
  logic [PW-1:0] ptr;
  logic [PW-1:0] start_fp;    // start index as fixed point
  logic [PW:0]   ptr_nxt;     // spare msb catches overflow
  logic [PW:0]   end_fp;      // (size+1) as fixed point
  logic [PW:0]   ptr_wrap;
  logic          past_end;
  logic          trig_q;
  logic          trig_d;
  logic          trig_rise;
  logic          start_req;

  assign start_fp = {i_start, 16'h0000};
  assign ptr_nxt  = {1'b0, ptr} + {1'b0, i_step};
  assign end_fp   = {({1'b0, i_size} + 1'b1), 16'h0000};
  assign past_end = (ptr_nxt >= end_fp);  // integer part beyond size
  assign ptr_wrap = ptr_nxt - end_fp;

  // external trigger is sampled once, then edge detected
  always_ff @(posedge dac_clk) begin
    if (i_rst) begin
      trig_q <= 1'b0;
      trig_d <= 1'b0;
    end else begin
      trig_q <= i_trig;
      trig_d <= trig_q;
    end
  end

  assign trig_rise = trig_q & ~trig_d;

  always_comb begin
    case (i_trig_src)
      TRIG_SW:  start_req = i_sw_start;
      TRIG_EXT: start_req = trig_rise;
      default:  start_req = 1'b0;        // TRIG_NONE and reserved codes
    endcase
  end

  // run state machine and pointer
  always_ff @(posedge dac_clk) begin
    if (i_rst) begin
      state   <= IDLE;
      ptr     <= '0;
      o_run_d <= 1'b0;
    end else begin
      o_run_d <= (state == RUN);          // lines up with table data
      if (i_hold) begin
        state <= IDLE;                     // held at start while rst set
        ptr   <= start_fp;
      end else begin
        case (state)
          IDLE: begin
            ptr <= start_fp;               // park on start index
            if (start_req) begin
              state <= RUN;
            end
          end
          RUN: begin
            if (!past_end) begin
              ptr <= ptr_nxt[PW-1:0];
            end else if (i_wrap) begin
              ptr <= ptr_wrap[PW-1:0];     // keep fraction across wrap
            end else begin
              state <= IDLE;               // single pass done
              ptr   <= start_fp;
            end
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

  assign o_raddr = ptr[PW-1:16];
  assign o_ptr   = ptr[PW-1:16];   // integer part for REG_PTR

endmodule

/* hw/asg_pkg.sv */
/*
 * Waveform generator shared definitions
 *   vector typedefs for samples, gain and bus words
 *   trigger source and sequencer state enums
 *   register offsets, channel stride and table base addresses
 */

package asg_pkg;

  typedef logic signed [13:0] dac_t;       // DAC sample or table entry
  typedef logic        [13:0] amp_t;       // unsigned gain with 0x2000 as unity
  typedef logic        [31:0] bus_addr_t;  // bus byte address
  typedef logic        [31:0] bus_data_t;  // bus data word

  // trigger source field of the per channel cfg byte
  typedef enum logic [2:0] {
    TRIG_NONE = 3'd0,  // channel never starts
    TRIG_SW   = 3'd1,  // start on cfg write
    TRIG_EXT  = 3'd2   // start on rising edge of trig input
  } trig_src_e;

  // pointer sequencer state
  typedef enum logic {
    IDLE = 1'b0,  // pointer parked at start
    RUN  = 1'b1   // pointer stepping
  } chan_state_e;

  // shared config register, A in bits 7..0, B in bits 23..16
  localparam bus_addr_t REG_CFG     = 32'h0000_0000;

  // per channel registers, channel B adds CH_STRIDE
  localparam bus_addr_t REG_AMP_OFS = 32'h0000_0004;  // amp 13..0, offset 29..16
  localparam bus_addr_t REG_SIZE    = 32'h0000_0008;  // last index in 29..16
  localparam bus_addr_t REG_START   = 32'h0000_000C;  // start index in 29..16
  localparam bus_addr_t REG_STEP    = 32'h0000_0010;  // 14.16 step in 29..0
  localparam bus_addr_t REG_PTR     = 32'h0000_0014;  // read only pointer
  localparam bus_addr_t CH_STRIDE   = 32'h0000_0020;

  // waveform tables, one word per index
  localparam bus_addr_t TABLE_BASE_A = 32'h0001_0000;
  localparam bus_addr_t TABLE_BASE_B = 32'h0002_0000;

endpackage

/* hw/asg_regs.sv */
/*
 * Bus register bank of the waveform generator
 *   cfg, amp/offset, size, start and step registers per channel
 *   software start pulses on cfg writes
 *   registered read mux with pointer readback
 *   table write and read steering, error on unmapped addresses
 */

`timescale 1ns/1ps

module asg_regs #(
  parameter int TABLE_AW = 14
) (
  input  logic                  dac_clk,
  input  logic                  i_rst,
  input  asg_pkg::bus_addr_t    i_addr,
  input  asg_pkg::bus_data_t    i_wdata,
  input  logic                  i_wen,
  input  logic                  i_ren,
  output asg_pkg::bus_data_t    o_rdata,
  output logic                  o_ack,
  output logic                  o_err,
  // channel A
  output asg_pkg::trig_src_e    o_cfg_trig_a,
  output logic                  o_wrap_a,
  output logic                  o_rst_a,
  output logic                  o_zero_a,
  output asg_pkg::amp_t         o_amp_a,
  output asg_pkg::dac_t         o_ofs_a,
  output logic [TABLE_AW-1:0]   o_size_a,
  output logic [TABLE_AW-1:0]   o_start_a,
  output logic [TABLE_AW+15:0]  o_step_a,
  output logic                  o_sw_start_a,
  input  logic [TABLE_AW-1:0]   i_ptr_a,
  output logic                  o_tbl_we_a,
  output logic [TABLE_AW-1:0]   o_tbl_addr_a,
  output asg_pkg::dac_t         o_tbl_wdata_a,
  input  asg_pkg::dac_t         i_tbl_rdata_a,
  // channel B
  output asg_pkg::trig_src_e    o_cfg_trig_b,
  output logic                  o_wrap_b,
  output logic                  o_rst_b,
  output logic                  o_zero_b,
  output asg_pkg::amp_t         o_amp_b,
  output asg_pkg::dac_t         o_ofs_b,
  output logic [TABLE_AW-1:0]   o_size_b,
  output logic [TABLE_AW-1:0]   o_start_b,
  output logic [TABLE_AW+15:0]  o_step_b,
  output logic                  o_sw_start_b,
  input  logic [TABLE_AW-1:0]   i_ptr_b,
  output logic                  o_tbl_we_b,
  output logic [TABLE_AW-1:0]   o_tbl_addr_b,
  output asg_pkg::dac_t         o_tbl_wdata_b,
  input  asg_pkg::dac_t         i_tbl_rdata_b
);
  import asg_pkg::*;

  localparam int PW = TABLE_AW + 16;  // pointer and step width

  logic [7:0]          cfg [2];        // zero, rst, wrap, trig_src
  amp_t                amp [2];
  dac_t                ofs [2];
  logic [TABLE_AW-1:0] size [2];
  logic [TABLE_AW-1:0] start [2];
  logic [PW-1:0]       step [2];
  logic [1:0]          sw_start;
  logic [TABLE_AW-1:0] ptr [2];
  dac_t                tbl_rdata [2];
  bus_addr_t           ch_ofs [2];     // address relative to channel base
  logic [1:0]          tbl_hit;        // access falls in table A or B
  logic                reg_hit;
  bus_data_t           reg_rdata;
  bus_data_t           rdata_q;
  logic [1:0]          rd_tbl_q;       // pending read returns table data

  assign ch_ofs[0]    = i_addr;
  assign ch_ofs[1]    = i_addr - CH_STRIDE;
  assign ptr[0]       = i_ptr_a;
  assign ptr[1]       = i_ptr_b;
  assign tbl_rdata[0] = i_tbl_rdata_a;
  assign tbl_rdata[1] = i_tbl_rdata_b;

  // table window is 2^TABLE_AW words above each base
  assign tbl_hit[0] = (i_addr[31:16] == TABLE_BASE_A[31:16]) &&
                      ((i_addr[15:2] >> TABLE_AW) == '0);
  assign tbl_hit[1] = (i_addr[31:16] == TABLE_BASE_B[31:16]) &&
                      ((i_addr[15:2] >> TABLE_AW) == '0);

  // register decode and read data
  always_comb begin
    reg_hit   = 1'b0;
    reg_rdata = '0;
    if (i_addr == REG_CFG) begin
      reg_hit   = 1'b1;
      reg_rdata = {8'h00, cfg[1], 8'h00, cfg[0]};
    end
    for (int c = 0; c < 2; c++) begin
      case (ch_ofs[c])
        REG_AMP_OFS: begin
          reg_hit   = 1'b1;
          reg_rdata = {2'b00, ofs[c], 2'b00, amp[c]};
        end
        REG_SIZE: begin
          reg_hit   = 1'b1;
          reg_rdata = bus_data_t'(size[c]) << 16;
        end
        REG_START: begin
          reg_hit   = 1'b1;
          reg_rdata = bus_data_t'(start[c]) << 16;
        end
        REG_STEP: begin
          reg_hit   = 1'b1;
          reg_rdata = bus_data_t'(step[c]);
        end
        REG_PTR: begin
          reg_hit   = 1'b1;          // writes are ignored
          reg_rdata = bus_data_t'(ptr[c]) << 16;
        end
        default: ;
      endcase
    end
  end

  // control register writes
  always_ff @(posedge dac_clk) begin
    if (i_rst) begin
      for (int c = 0; c < 2; c++) begin
        cfg[c]   <= '0;
        amp[c]   <= '0;
        ofs[c]   <= '0;
        size[c]  <= '0;
        start[c] <= '0;
        step[c]  <= '0;
      end
      sw_start <= '0;
    end else begin
      sw_start <= '0;                            // single cycle pulses
      if (i_wen && (i_addr == REG_CFG)) begin
        cfg[0]      <= i_wdata[7:0];
        cfg[1]      <= i_wdata[23:16];
        sw_start[0] <= (i_wdata[2:0] == TRIG_SW);
        sw_start[1] <= (i_wdata[18:16] == TRIG_SW);
      end
      for (int c = 0; c < 2; c++) begin
        if (i_wen) begin
          case (ch_ofs[c])
            REG_AMP_OFS: begin
              amp[c] <= i_wdata[13:0];
              ofs[c] <= i_wdata[29:16];
            end
            REG_SIZE:  size[c]  <= i_wdata[16 +: TABLE_AW];
            REG_START: start[c] <= i_wdata[16 +: TABLE_AW];
            REG_STEP:  step[c]  <= i_wdata[PW-1:0];
            default: ;
          endcase
        end
      end
    end
  end

  // ack and error one cycle after the strobe
  always_ff @(posedge dac_clk) begin
    if (i_rst) begin
      o_ack    <= 1'b0;
      o_err    <= 1'b0;
      rd_tbl_q <= '0;
    end else begin
      o_ack    <= i_wen | i_ren;
      o_err    <= (i_wen | i_ren) & ~(reg_hit | (|tbl_hit));
      rd_tbl_q <= i_ren ? tbl_hit : 2'b00;
    end
  end

  always_ff @(posedge dac_clk) begin
    if (i_ren) begin
      rdata_q <= reg_rdata;
    end
  end

  // table words return sign extended from the table's bus port
  always_comb begin
    if (rd_tbl_q[0]) begin
      o_rdata = {{18{tbl_rdata[0][13]}}, tbl_rdata[0]};
    end else if (rd_tbl_q[1]) begin
      o_rdata = {{18{tbl_rdata[1][13]}}, tbl_rdata[1]};
    end else begin
      o_rdata = rdata_q;
    end
  end

  assign o_cfg_trig_a  = trig_src_e'(cfg[0][2:0]);
  assign o_wrap_a      = cfg[0][3];
  assign o_rst_a       = cfg[0][4];
  assign o_zero_a      = cfg[0][5];
  assign o_amp_a       = amp[0];
  assign o_ofs_a       = ofs[0];
  assign o_size_a      = size[0];
  assign o_start_a     = start[0];
  assign o_step_a      = step[0];
  assign o_sw_start_a  = sw_start[0];
  assign o_tbl_we_a    = i_wen & tbl_hit[0];
  assign o_tbl_addr_a  = i_addr[TABLE_AW+1:2];   // word index
  assign o_tbl_wdata_a = i_wdata[13:0];

  assign o_cfg_trig_b  = trig_src_e'(cfg[1][2:0]);
  assign o_wrap_b      = cfg[1][3];
  assign o_rst_b       = cfg[1][4];
  assign o_zero_b      = cfg[1][5];
  assign o_amp_b       = amp[1];
  assign o_ofs_b       = ofs[1];
  assign o_size_b      = size[1];
  assign o_start_b     = start[1];
  assign o_step_b      = step[1];
  assign o_sw_start_b  = sw_start[1];
  assign o_tbl_we_b    = i_wen & tbl_hit[1];
  assign o_tbl_addr_b  = i_addr[TABLE_AW+1:2];
  assign o_tbl_wdata_b = i_wdata[13:0];

endmodule

/* hw/asg_scale.sv */
/*
 * Output scaler
 *   sample times gain, shifted by 13
 *   DC offset add and 14 bit saturation
 *   idle and zero forcing, registered output
 */

`timescale 1ns/1ps

module asg_scale (
  input  logic          dac_clk,
  input  logic          i_rst,
  input  asg_pkg::dac_t i_data,
  input  logic          i_run,
  input  asg_pkg::amp_t i_amp,
  input  asg_pkg::dac_t i_ofs,
  input  logic          i_zero,
  output asg_pkg::dac_t o_dac
);
  import asg_pkg::*;

  localparam int DAC_MAX = 8191;
  localparam int DAC_MIN = -8192;

  dac_t               smp;    // sample, 0 while idle
  logic signed [28:0] prod;
  logic signed [15:0] scl;    // product >>> 13
  logic signed [16:0] sum;
  dac_t               sat;

  assign smp  = i_run ? i_data : '0;
  assign prod = smp * $signed({1'b0, i_amp});  // gain is unsigned
  assign scl  = prod[28:13];
  assign sum  = scl + i_ofs;

  always_comb begin
    if (sum > DAC_MAX) begin
      sat = dac_t'(DAC_MAX);
    end else if (sum < DAC_MIN) begin
      sat = dac_t'(DAC_MIN);
    end else begin
      sat = sum[13:0];
    end
  end

  always_ff @(posedge dac_clk) begin
    if (i_rst) begin
      o_dac <= '0;
    end else begin
      o_dac <= i_zero ? '0 : sat;  // zero wins over offset
    end
  end

endmodule

/* hw/asg_table.sv */
/*
 * Waveform table memory
 *   bus port with write and registered readback
 *   registered read port for the channel sequencer
 */

`timescale 1ns/1ps

module asg_table #(
  parameter int TABLE_AW = 14
) (
  input  logic                dac_clk,
  input  logic                i_we,
  input  logic [TABLE_AW-1:0] i_waddr,
  input  asg_pkg::dac_t       i_wdata,
  output asg_pkg::dac_t       o_bus_rdata,
  input  logic [TABLE_AW-1:0] i_raddr,
  output asg_pkg::dac_t       o_rdata
);
  import asg_pkg::*;

  dac_t mem [2**TABLE_AW];  // one sample per index

  // bus side, read returns the old word on a write
  always_ff @(posedge dac_clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
    o_bus_rdata <= mem[i_waddr];
  end

  // playback side
  always_ff @(posedge dac_clk) begin
    o_rdata <= mem[i_raddr];  // one cycle behind pointer
  end

endmodule

/* hw/asg_top.sv */
/*
 * Two channel arbitrary waveform generator top
 *   bus register bank
 *   per channel table, pointer sequencer and output scaler
 */

`timescale 1ns/1ps

module asg_top #(
  parameter int TABLE_AW = 14
) (
  input  logic               dac_clk,
  input  logic               i_rst,
  input  asg_pkg::bus_addr_t i_addr,
  input  asg_pkg::bus_data_t i_wdata,
  input  logic               i_wen,
  input  logic               i_ren,
  output asg_pkg::bus_data_t o_rdata,
  output logic               o_ack,
  output logic               o_err,
  input  logic               i_trig_a,
  input  logic               i_trig_b,
  output asg_pkg::dac_t      o_dac_a,
  output asg_pkg::dac_t      o_dac_b
);
  import asg_pkg::*;

  localparam int PW = TABLE_AW + 16;

  // index 0 is channel A, 1 is channel B
  trig_src_e           cfg_trig [2];
  logic [1:0]          wrap;
  logic [1:0]          hold;
  logic [1:0]          zero;
  logic [1:0]          sw_start;
  logic [1:0]          tbl_we;
  logic [1:0]          run_d;
  logic [1:0]          trig;
  amp_t                amp [2];
  dac_t                ofs [2];
  logic [TABLE_AW-1:0] size [2];
  logic [TABLE_AW-1:0] start [2];
  logic [PW-1:0]       step [2];
  logic [TABLE_AW-1:0] ptr [2];
  logic [TABLE_AW-1:0] raddr [2];
  logic [TABLE_AW-1:0] tbl_addr [2];
  dac_t                tbl_wdata [2];
  dac_t                tbl_bus_rdata [2];
  dac_t                smp [2];
  dac_t                dac [2];

  assign trig    = {i_trig_b, i_trig_a};
  assign o_dac_a = dac[0];
  assign o_dac_b = dac[1];

  asg_regs #(
    .TABLE_AW (TABLE_AW)
  ) i_regs (
    .dac_clk       (dac_clk),
    .i_rst         (i_rst),
    .i_addr        (i_addr),
    .i_wdata       (i_wdata),
    .i_wen         (i_wen),
    .i_ren         (i_ren),
    .o_rdata       (o_rdata),
    .o_ack         (o_ack),
    .o_err         (o_err),
    .o_cfg_trig_a  (cfg_trig[0]),
    .o_wrap_a      (wrap[0]),
    .o_rst_a       (hold[0]),
    .o_zero_a      (zero[0]),
    .o_amp_a       (amp[0]),
    .o_ofs_a       (ofs[0]),
    .o_size_a      (size[0]),
    .o_start_a     (start[0]),
    .o_step_a      (step[0]),
    .o_sw_start_a  (sw_start[0]),
    .i_ptr_a       (ptr[0]),
    .o_tbl_we_a    (tbl_we[0]),
    .o_tbl_addr_a  (tbl_addr[0]),
    .o_tbl_wdata_a (tbl_wdata[0]),
    .i_tbl_rdata_a (tbl_bus_rdata[0]),
    .o_cfg_trig_b  (cfg_trig[1]),
    .o_wrap_b      (wrap[1]),
    .o_rst_b       (hold[1]),
    .o_zero_b      (zero[1]),
    .o_amp_b       (amp[1]),
    .o_ofs_b       (ofs[1]),
    .o_size_b      (size[1]),
    .o_start_b     (start[1]),
    .o_step_b      (step[1]),
    .o_sw_start_b  (sw_start[1]),
    .i_ptr_b       (ptr[1]),
    .o_tbl_we_b    (tbl_we[1]),
    .o_tbl_addr_b  (tbl_addr[1]),
    .o_tbl_wdata_b (tbl_wdata[1]),
    .i_tbl_rdata_b (tbl_bus_rdata[1])
  );

  for (genvar c = 0; c < 2; c++) begin : g_ch
    asg_table #(
      .TABLE_AW (TABLE_AW)
    ) i_table (
      .dac_clk     (dac_clk),
      .i_we        (tbl_we[c]),
      .i_waddr     (tbl_addr[c]),
      .i_wdata     (tbl_wdata[c]),
      .o_bus_rdata (tbl_bus_rdata[c]),
      .i_raddr     (raddr[c]),
      .o_rdata     (smp[c])
    );

    asg_chan #(
      .TABLE_AW (TABLE_AW)
    ) i_chan (
      .dac_clk    (dac_clk),
      .i_rst      (i_rst),
      .i_trig     (trig[c]),
      .i_trig_src (cfg_trig[c]),
      .i_sw_start (sw_start[c]),
      .i_wrap     (wrap[c]),
      .i_hold     (hold[c]),
      .i_size     (size[c]),
      .i_start    (start[c]),
      .i_step     (step[c]),
      .o_raddr    (raddr[c]),
      .o_run_d    (run_d[c]),
      .o_ptr      (ptr[c])
    );

    asg_scale i_scale (
      .dac_clk (dac_clk),
      .i_rst   (i_rst),
      .i_data  (smp[c]),
      .i_run   (run_d[c]),
      .i_amp   (amp[c]),
      .i_ofs   (ofs[c]),
      .i_zero  (zero[c]),
      .o_dac   (dac[c])
    );
  end

endmodule

/* testbench/asg_chk.sv */
/*
 * Bus timing and control checks for the register bank
 *   acknowledge exactly one cycle after each strobe
 *   error only with acknowledge
 *   start pulses follow cfg writes with a software trigger
 *   zero bit follows a cfg write
 */

`timescale 1ns/1ps

module asg_chk (
  input logic               dac_clk,
  input logic               i_rst,
  input asg_pkg::bus_addr_t i_addr,
  input asg_pkg::bus_data_t i_wdata,
  input logic               i_wen,
  input logic               i_ren,
  input logic               o_ack,
  input logic               o_err,
  input logic               o_zero_a,
  input logic               o_zero_b,
  input logic               o_sw_start_a,
  input logic               o_sw_start_b
);
  import asg_pkg::*;

  a_ack: assert property (@(posedge dac_clk) disable iff (i_rst)
    (i_wen || i_ren) |=> o_ack) else $error("strobe without acknowledge");
  a_no_ack: assert property (@(posedge dac_clk) disable iff (i_rst)
    !(i_wen || i_ren) |=> !o_ack) else $error("acknowledge without strobe");
  a_err: assert property (@(posedge dac_clk) disable iff (i_rst)
    o_err |-> o_ack) else $error("error flag outside acknowledge");
  a_start_a: assert property (@(posedge dac_clk) disable iff (i_rst)
    o_sw_start_a == $past(i_wen && i_addr == REG_CFG && i_wdata[2:0] == TRIG_SW))
    else $error("start pulse a does not match the cfg write");
  a_start_b: assert property (@(posedge dac_clk) disable iff (i_rst)
    o_sw_start_b == $past(i_wen && i_addr == REG_CFG && i_wdata[18:16] == TRIG_SW))
    else $error("start pulse b does not match the cfg write");
  a_zero_a: assert property (@(posedge dac_clk) disable iff (i_rst)
    (i_wen && i_addr == REG_CFG) |=> (o_zero_a == $past(i_wdata[5])))
    else $error("zero a does not follow cfg");
  a_zero_b: assert property (@(posedge dac_clk) disable iff (i_rst)
    (i_wen && i_addr == REG_CFG) |=> (o_zero_b == $past(i_wdata[21])))
    else $error("zero b does not follow cfg");

endmodule

/* testbench/asg_tb.sv */
/*
 * Testbench for the two channel waveform generator
 *   clock, reset, bus write and read tasks
 *   cycle-true reference model of pointers, tables and scalers
 *   compare tasks, directed and random tests, watchdog
 */

`timescale 1ns/1ps

module asg_tb;
  import asg_pkg::*;

  localparam int TABLE_AW = 10;
  localparam int CLK_NS   = 4;
  localparam int TBL_N    = 2**TABLE_AW;
  // watchdog allows twice the summed cycle budgets
  localparam int T_READBACK = 500;
  localparam int T_SINGLE   = 60;
  localparam int T_WRAP     = 340;
  localparam int T_SCALE    = 140;
  localparam int T_CTRL     = 100;
  localparam int WATCHDOG_NS =
    (T_READBACK + T_SINGLE + T_WRAP + T_SCALE + T_CTRL) * CLK_NS * 2;

  logic      dac_clk;
  logic      i_rst;
  bus_addr_t i_addr;
  bus_data_t i_wdata;
  logic      i_wen;
  logic      i_ren;
  bus_data_t o_rdata;
  logic      o_ack;
  logic      o_err;
  logic      trig_a;
  logic      trig_b;
  dac_t      o_dac_a;
  dac_t      o_dac_b;

  integer    seed;
  int        err_cnt;
  string     test_name;
  bit        cmp_en;
  logic [7:0] cfg_a;                  // tb copy of the cfg bytes
  logic [7:0] cfg_b;

  // reference model state with index 0 for A
  logic [7:0] m_cfg [2];
  amp_t       m_amp [2];
  dac_t       m_ofs [2];
  longint     m_size [2];
  longint     m_start [2];
  longint     m_step [2];
  bit         m_sw [2];
  bit         m_state [2];            // 1 while running
  longint     m_ptr [2];              // 16 fraction bits
  bit         m_run_d [2];
  dac_t       m_smp [2];
  dac_t       m_dac [2];
  bit         m_tq [2];
  bit         m_td [2];
  dac_t       m_mem [2][TBL_N];

  asg_top #(
    .TABLE_AW (TABLE_AW)
  ) i_asg_top (
    .dac_clk  (dac_clk),
    .i_rst    (i_rst),
    .i_addr   (i_addr),
    .i_wdata  (i_wdata),
    .i_wen    (i_wen),
    .i_ren    (i_ren),
    .o_rdata  (o_rdata),
    .o_ack    (o_ack),
    .o_err    (o_err),
    .i_trig_a (trig_a),
    .i_trig_b (trig_b),
    .o_dac_a  (o_dac_a),
    .o_dac_b  (o_dac_b)
  );

  bind asg_regs asg_chk i_asg_chk (
    .dac_clk      (dac_clk),
    .i_rst        (i_rst),
    .i_addr       (i_addr),
    .i_wdata      (i_wdata),
    .i_wen        (i_wen),
    .i_ren        (i_ren),
    .o_ack        (o_ack),
    .o_err        (o_err),
    .o_zero_a     (o_zero_a),
    .o_zero_b     (o_zero_b),
    .o_sw_start_a (o_sw_start_a),
    .o_sw_start_b (o_sw_start_b)
  );

  initial begin
    dac_clk = 1'b0;
    forever #(CLK_NS / 2) dac_clk = ~dac_clk;
  end

  // product >>> 13 plus offset then clipped to 14 bits
  function automatic dac_t scale_ref(input dac_t smp, input bit run, input amp_t amp,
                                     input dac_t ofs, input bit zero);
    longint s;
    longint v;
    s = run ? longint'(smp) : 0;      // idle input counts as 0
    v = ((s * longint'(amp)) >>> 13) + longint'(ofs);
    if (v > 8191) v = 8191;
    else if (v < -8192) v = -8192;
    if (zero) v = 0;
    return dac_t'(v);
  endfunction

  // model steps on the same edges as the DUT
  always @(posedge dac_clk) begin
    longint nxt;
    longint endf;
    bus_addr_t off;
    bit req;
    if (i_rst) begin
      for (int c = 0; c < 2; c++) begin
        m_cfg[c]   = '0;
        m_amp[c]   = '0;
        m_ofs[c]   = '0;
        m_size[c]  = 0;
        m_start[c] = 0;
        m_step[c]  = 0;
        m_sw[c]    = 0;
        m_state[c] = 0;
        m_ptr[c]   = 0;
        m_run_d[c] = 0;
        m_dac[c]   = '0;
        m_tq[c]    = 0;
        m_td[c]    = 0;
      end
    end else begin
      for (int c = 0; c < 2; c++) begin
        m_dac[c]   = scale_ref(m_smp[c], m_run_d[c], m_amp[c], m_ofs[c], m_cfg[c][5]);
        m_smp[c]   = m_mem[c][m_ptr[c] >> 16];
        m_run_d[c] = m_state[c];
        case (m_cfg[c][2:0])
          3'd1:    req = m_sw[c];
          3'd2:    req = m_tq[c] & ~m_td[c];
          default: req = 1'b0;
        endcase
        nxt  = m_ptr[c] + m_step[c];
        endf = (m_size[c] + 1) << 16;
        if (m_cfg[c][4]) begin           // rst bit holds at start
          m_state[c] = 0;
          m_ptr[c]   = m_start[c] << 16;
        end else if (!m_state[c]) begin
          m_ptr[c] = m_start[c] << 16;
          if (req) m_state[c] = 1;
        end else if (nxt < endf) begin
          m_ptr[c] = nxt;
        end else if (m_cfg[c][3]) begin
          m_ptr[c] = nxt - endf;         // wrap keeps the fraction
        end else begin
          m_state[c] = 0;
          m_ptr[c]   = m_start[c] << 16;
        end
        m_td[c] = m_tq[c];
        m_tq[c] = (c == 0) ? trig_a : trig_b;
      end
      m_sw[0] = 0;
      m_sw[1] = 0;
      if (i_wen) begin                   // register and table writes
        if (i_addr == REG_CFG) begin
          m_cfg[0] = i_wdata[7:0];
          m_cfg[1] = i_wdata[23:16];
          m_sw[0]  = (i_wdata[2:0] == 3'd1);
          m_sw[1]  = (i_wdata[18:16] == 3'd1);
        end
        for (int c = 0; c < 2; c++) begin
          off = i_addr - bus_addr_t'(c * 32);
          case (off)
            32'h04: begin
              m_amp[c] = i_wdata[13:0];
              m_ofs[c] = i_wdata[29:16];
            end
            32'h08:  m_size[c]  = i_wdata[25:16];
            32'h0C:  m_start[c] = i_wdata[25:16];
            32'h10:  m_step[c]  = i_wdata[25:0];
            default: ;
          endcase
          if (i_addr[31:16] == c + 1 && i_addr[15:12] == 4'h0)
            m_mem[c][i_addr[11:2]] = i_wdata[13:0];
        end
      end
    end
  end

  task automatic fail_run(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_dac(input string what, input dac_t exp, input dac_t act);
    if (act !== exp)
      fail_run($sformatf("Mismatch %s %s: expected %0d, actual %0d",
                         test_name, what, exp, act));
  endtask

  task automatic check_word(input string what, input bus_data_t exp, input bus_data_t act);
    if (act !== exp)
      fail_run($sformatf("Mismatch %s %s: expected 0x%08h, actual 0x%08h",
                         test_name, what, exp, act));
  endtask

  // both outputs against the model on the falling edge
  always @(negedge dac_clk) begin
    if (cmp_en) begin
      check_dac("o_dac_a", m_dac[0], o_dac_a);
      check_dac("o_dac_b", m_dac[1], o_dac_b);
    end
  end

  task automatic step_cycles(input int n);
    repeat (n) @(posedge dac_clk);
    #1;
  endtask

  task automatic wait_ack();
    int n;
    n = 0;
    while (!o_ack && n < 8) begin
      step_cycles(1);
      n++;
    end
    if (!o_ack) fail_run("Bus access got no acknowledge");
  endtask

  task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
    i_addr  = addr;
    i_wdata = data;
    i_wen   = 1'b1;
    step_cycles(1);
    i_wen   = 1'b0;
    wait_ack();
  endtask

  task automatic bus_read(input bus_addr_t addr, output bus_data_t data, output logic err);
    i_addr = addr;
    i_ren  = 1'b1;
    step_cycles(1);
    i_ren  = 1'b0;
    wait_ack();
    data = o_rdata;
    err  = o_err;
  endtask

  task automatic write_cfg();
    bus_write(REG_CFG, {8'h00, cfg_b, 8'h00, cfg_a});
  endtask

  task automatic read_expect(input string what, input bus_addr_t addr, input bus_data_t exp);
    bus_data_t d;
    logic e;
    bus_read(addr, d, e);
    check_word({what, " err"}, 32'd0, {31'd0, e});
    check_word(what, exp, d);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the simulation hung");
    $display("Errors found");
    $fatal(1);
  end

  initial begin
    bus_data_t w;
    bus_data_t d;
    logic e;
    i_rst   = 1'b1;
    i_addr  = '0;
    i_wdata = '0;
    i_wen   = 1'b0;
    i_ren   = 1'b0;
    trig_a  = 1'b0;
    trig_b  = 1'b0;
    seed    = 32'hbb45_e75a;
    err_cnt = 0;
    cmp_en  = 1'b0;
    cfg_a   = '0;
    cfg_b   = '0;
    for (int i = 0; i < TBL_N; i++) begin
      m_mem[0][i] = '0;
      m_mem[1][i] = '0;
    end
    repeat (4) @(posedge dac_clk);
    #1 i_rst = 1'b0;
    cmp_en = 1'b1;

    test_name = "readback";
    for (int i = 0; i < 64; i++) begin
      bus_write(TABLE_BASE_A + 4 * i, $random(seed));
      bus_write(TABLE_BASE_B + 4 * i, $random(seed));
    end
    for (int i = 0; i < 8; i++) begin
      read_expect("table a", TABLE_BASE_A + 4 * i, {{18{m_mem[0][i][13]}}, m_mem[0][i]});
      read_expect("table b", TABLE_BASE_B + 4 * i, {{18{m_mem[1][i][13]}}, m_mem[1][i]});
    end
    w = $random(seed);
    bus_write(REG_STEP, w);
    read_expect("step a", REG_STEP, w & 32'h03FF_FFFF);
    w = $random(seed);
    bus_write(REG_SIZE + CH_STRIDE, w);
    read_expect("size b", REG_SIZE + CH_STRIDE, w & 32'h03FF_0000);
    w = $random(seed);
    bus_write(REG_START + CH_STRIDE, w);
    read_expect("start b", REG_START + CH_STRIDE, w & 32'h03FF_0000);
    w = $random(seed);
    bus_write(REG_AMP_OFS + CH_STRIDE, w);
    read_expect("amp_ofs b", REG_AMP_OFS + CH_STRIDE, w & 32'h3FFF_3FFF);
    cfg_a = 8'h08;
    cfg_b = 8'h20;
    write_cfg();
    read_expect("cfg", REG_CFG, 32'h0020_0008);
    bus_read(32'h0000_0018, d, e);       // hole in the map
    check_word("unmapped err", 32'd1, {31'd0, e});

    test_name = "single pass";
    bus_write(REG_AMP_OFS, 32'h0064_2000);  // unity gain and offset 100
    bus_write(REG_SIZE, 32'h0007_0000);
    bus_write(REG_START, 32'h0000_0000);
    bus_write(REG_STEP, 32'h0001_0000);
    cfg_a = 8'h01;
    cfg_b = 8'h00;
    write_cfg();
    step_cycles(16);                     // 8 samples plus latency
    check_dac("idle level", 14'sd100, o_dac_a);
    read_expect("ptr a", REG_PTR, 32'h0000_0000);

    test_name = "wrap ext";
    bus_write(REG_AMP_OFS + CH_STRIDE, 32'h3FCE_1800);  // offset -50
    bus_write(REG_SIZE + CH_STRIDE, 32'h0028_0000);
    bus_write(REG_START + CH_STRIDE, 32'h0005_0000);
    bus_write(REG_STEP + CH_STRIDE, 32'h0000_8000 + ($random(seed) & 32'h0000_FFFF));
    cfg_b = 8'h0A;
    write_cfg();
    step_cycles(3);
    trig_b = 1'b1;
    step_cycles(3);
    trig_b = 1'b0;
    step_cycles(300);

    test_name = "saturation";
    bus_write(TABLE_BASE_A + 0, 32'h0000_1FFF);
    bus_write(TABLE_BASE_A + 4, 32'h0000_2000);
    bus_write(TABLE_BASE_A + 8, 32'h0000_1FFF);
    bus_write(TABLE_BASE_A + 12, 32'h0000_2000);
    bus_write(REG_SIZE, 32'h0003_0000);
    bus_write(REG_AMP_OFS, 32'h0FA0_3FFF);  // near 2x gain and offset 4000
    cfg_a = 8'h09;
    write_cfg();
    step_cycles(20);
    bus_write(REG_AMP_OFS, 32'h20C0_1000);  // half gain and offset -8000
    step_cycles(20);
    bus_write(REG_AMP_OFS, 32'h2000_3FFF);  // offset -8192
    step_cycles(20);
    bus_write(REG_AMP_OFS, 32'h1FFF_3FFF);  // offset 8191
    step_cycles(20);

    test_name = "controls";
    cfg_a = 8'h29;                       // zero set and sw start while running
    write_cfg();
    step_cycles(3);
    check_dac("zero", 14'sd0, o_dac_a);
    trig_b = 1'b1;                       // edge ignored since b is running
    step_cycles(3);
    trig_b = 1'b0;
    step_cycles(20);
    bus_write(REG_START, 32'h0002_0000);
    cfg_a = 8'h18;
    write_cfg();
    step_cycles(3);
    read_expect("ptr after rst", REG_PTR, 32'h0002_0000);
    step_cycles(5);

    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
